// File: hdl/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// slot 0 is reserved, so one slot less is usable
`define ROB_DEPTH 16
`define TAG_W     4

`define DATA_W    32
`define REG_W     5
`define ADDR_W    32

`endif

// File: hdl/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    // operation class carried by each buffer entry
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_branch = 2'd1,
        op_store  = 2'd2
    } op_kind_e;

    // tag 0 means the value sits in the register file
    typedef logic [`TAG_W-1:0] tag_t;

    typedef logic [`REG_W-1:0] reg_name_t;

    typedef logic [`DATA_W-1:0] data_t;

    typedef logic [`ADDR_W-1:0] addr_t;

endpackage

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  rob_pkg::op_kind_e  alloc_op,
    input  rob_pkg::reg_name_t alloc_rd,
    input  logic               alloc_pred_taken,
    output logic               full,
    output rob_pkg::tag_t      alloc_tag,
    output logic               alloc_fire,
    input  logic               ex_valid,
    input  rob_pkg::tag_t      ex_tag,
    input  rob_pkg::data_t     ex_data,
    input  logic               ex_taken,
    input  rob_pkg::addr_t     ex_target,
    input  rob_pkg::tag_t      lookup1_tag,
    input  rob_pkg::tag_t      lookup2_tag,
    output logic               lookup1_done,
    output logic               lookup2_done,
    output rob_pkg::data_t     lookup1_data,
    output rob_pkg::data_t     lookup2_data,
    output logic               commit_valid,
    output rob_pkg::reg_name_t commit_rd,
    output rob_pkg::data_t     commit_data,
    output rob_pkg::tag_t      commit_tag,
    output logic               store_commit,
    output rob_pkg::tag_t      store_tag,
    output logic               redirect_valid,
    output rob_pkg::addr_t     redirect_pc,
    output logic               flush
);

    localparam int DEPTH = `ROB_DEPTH;

    logic [DEPTH-1:0]   busy;
    logic [DEPTH-1:0]   done;
    logic [DEPTH-1:0]   pred_taken;
    logic [DEPTH-1:0]   act_taken;
    rob_pkg::op_kind_e  op_q     [DEPTH];
    rob_pkg::reg_name_t rd_q     [DEPTH];
    rob_pkg::data_t     data_q   [DEPTH];
    rob_pkg::addr_t     target_q [DEPTH];

    rob_pkg::tag_t head;
    rob_pkg::tag_t tail;

    logic retire_go;
    logic mispredict;

    // pointers skip slot 0 on wrap
    function automatic rob_pkg::tag_t wrap_inc(input rob_pkg::tag_t p);
        if (p == rob_pkg::tag_t'(DEPTH - 1)) begin
            return rob_pkg::tag_t'(1);
        end
        return p + rob_pkg::tag_t'(1);
    endfunction

    // tail slot still busy means all 15 usable slots are taken
    assign full       = busy[tail];
    assign alloc_tag  = tail;
    assign alloc_fire = alloc_valid && !full;

    assign retire_go  = busy[head] && done[head];
    assign mispredict = (op_q[head] == rob_pkg::op_branch)
                        && (pred_taken[head] != act_taken[head]);

    // done survives retire so lookups stay valid during the commit cycle
    assign lookup1_done = done[lookup1_tag];
    assign lookup2_done = done[lookup2_tag];
    assign lookup1_data = data_q[lookup1_tag];
    assign lookup2_data = data_q[lookup2_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= '0;
            done           <= '0;
            head           <= rob_pkg::tag_t'(1);
            tail           <= rob_pkg::tag_t'(1);
            commit_valid   <= 1'b0;
            store_commit   <= 1'b0;
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
        end else begin
            commit_valid   <= retire_go && (op_q[head] == rob_pkg::op_alu);
            store_commit   <= retire_go && (op_q[head] == rob_pkg::op_store);
            redirect_valid <= retire_go && mispredict;
            flush          <= retire_go && mispredict;

            if (alloc_fire) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= wrap_inc(tail);
            end

            if (ex_valid) begin
                done[ex_tag] <= 1'b1;
            end

            if (retire_go) begin
                busy[head] <= 1'b0;
                head       <= wrap_inc(head);
            end

            // wrong path: drop everything younger, restart at slot 1
            if (retire_go && mispredict) begin
                busy <= '0;
                done <= '0;
                head <= rob_pkg::tag_t'(1);
                tail <= rob_pkg::tag_t'(1);
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            op_q[tail]       <= alloc_op;
            rd_q[tail]       <= alloc_rd;
            pred_taken[tail] <= alloc_pred_taken;
        end
        if (ex_valid) begin
            data_q[ex_tag]    <= ex_data;
            act_taken[ex_tag] <= ex_taken;
            target_q[ex_tag]  <= ex_target;
        end
    end

    // retire payload, qualified by the valid pulses above
    always_ff @(posedge clk) begin
        commit_rd   <= rd_q[head];
        commit_data <= data_q[head];
        commit_tag  <= head;
        store_tag   <= head;
        redirect_pc <= target_q[head];
    end

    a_ex_busy : assert property (
        @(posedge clk) disable iff (rst)
        ex_valid |-> busy[ex_tag]
    ) else $error("completion names a slot that is not allocated");

    // an accepted allocation must still find a free usable slot
    a_no_alloc_full : assert property (
        @(posedge clk) disable iff (rst)
        alloc_fire |-> ($countones(busy) < DEPTH - 1)
    ) else $error("allocation taken while full");

    // outside a flush at most one entry leaves per edge
    a_one_retire : assert property (
        @(posedge clk) disable iff (rst)
        !flush |-> ($countones($past(busy) & ~busy) <= 1)
    ) else $error("more than one entry retired in one cycle");

endmodule

// File: hdl/rename_map.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rename_map (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_fire,
    input  rob_pkg::reg_name_t alloc_rd,
    input  rob_pkg::tag_t      alloc_tag,
    input  logic               commit_valid,
    input  rob_pkg::reg_name_t commit_rd,
    input  rob_pkg::tag_t      commit_tag,
    input  logic               flush,
    input  rob_pkg::reg_name_t src1_name,
    input  rob_pkg::reg_name_t src2_name,
    input  rob_pkg::data_t     rf_data1,
    input  rob_pkg::data_t     rf_data2,
    input  logic               lookup1_done,
    input  logic               lookup2_done,
    input  rob_pkg::data_t     lookup1_data,
    input  rob_pkg::data_t     lookup2_data,
    output rob_pkg::tag_t      lookup1_tag,
    output rob_pkg::tag_t      lookup2_tag,
    output logic               src1_ready,
    output logic               src2_ready,
    output rob_pkg::tag_t      src1_tag,
    output rob_pkg::tag_t      src2_tag,
    output rob_pkg::data_t     src1_data,
    output rob_pkg::data_t     src2_data
);

    localparam int NREGS = 1 << `REG_W;

    // youngest producer per architectural register
    rob_pkg::tag_t map_q [NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            if (flush) begin
                for (int i = 0; i < NREGS; i++) begin
                    map_q[i] <= '0;
                end
            end else if (commit_valid && (map_q[commit_rd] == commit_tag)) begin
                map_q[commit_rd] <= '0;
            end
            // a new producer overrides a clear to the same register
            if (alloc_fire && (alloc_rd != '0)) begin
                map_q[alloc_rd] <= alloc_tag;
            end
        end
    end

    assign lookup1_tag = map_q[src1_name];
    assign lookup2_tag = map_q[src2_name];

    assign src1_tag   = lookup1_tag;
    assign src1_ready = (lookup1_tag == '0) || lookup1_done;
    assign src1_data  = (lookup1_tag == '0) ? rf_data1 : lookup1_data;

    assign src2_tag   = lookup2_tag;
    assign src2_ready = (lookup2_tag == '0) || lookup2_done;
    assign src2_data  = (lookup2_tag == '0) ? rf_data2 : lookup2_data;

endmodule

// File: hdl/arch_regfile.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module arch_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               commit_valid,
    input  rob_pkg::reg_name_t commit_rd,
    input  rob_pkg::data_t     commit_data,
    input  rob_pkg::reg_name_t src1_name,
    input  rob_pkg::reg_name_t src2_name,
    output rob_pkg::data_t     rf_data1,
    output rob_pkg::data_t     rf_data2
);

    localparam int NREGS = 1 << `REG_W;

    rob_pkg::data_t regs [NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && (commit_rd != '0)) begin
            regs[commit_rd] <= commit_data;
        end
    end

    // x0 is hardwired
    assign rf_data1 = (src1_name == '0) ? '0 : regs[src1_name];
    assign rf_data2 = (src2_name == '0) ? '0 : regs[src2_name];

endmodule

// File: hdl/ooo_retire_top.sv
`timescale 1ns/1ps

module ooo_retire_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  rob_pkg::op_kind_e  alloc_op,
    input  rob_pkg::reg_name_t alloc_rd,
    input  logic               alloc_pred_taken,
    output logic               full,
    output rob_pkg::tag_t      alloc_tag,
    input  rob_pkg::reg_name_t src1_name,
    input  rob_pkg::reg_name_t src2_name,
    output logic               src1_ready,
    output rob_pkg::tag_t      src1_tag,
    output rob_pkg::data_t     src1_data,
    output logic               src2_ready,
    output rob_pkg::tag_t      src2_tag,
    output rob_pkg::data_t     src2_data,
    input  logic               ex_valid,
    input  rob_pkg::tag_t      ex_tag,
    input  rob_pkg::data_t     ex_data,
    input  logic               ex_taken,
    input  rob_pkg::addr_t     ex_target,
    output logic               commit_valid,
    output rob_pkg::reg_name_t commit_rd,
    output rob_pkg::data_t     commit_data,
    output rob_pkg::tag_t      commit_tag,
    output logic               store_commit,
    output rob_pkg::tag_t      store_tag,
    output logic               redirect_valid,
    output rob_pkg::addr_t     redirect_pc
);

    logic           alloc_fire;
    logic           flush;
    rob_pkg::tag_t  lookup1_tag;
    rob_pkg::tag_t  lookup2_tag;
    logic           lookup1_done;
    logic           lookup2_done;
    rob_pkg::data_t lookup1_data;
    rob_pkg::data_t lookup2_data;
    rob_pkg::data_t rf_data1;
    rob_pkg::data_t rf_data2;

    reorder_buffer rob0 (
        .clk              (clk),
        .rst              (rst),
        .alloc_valid      (alloc_valid),
        .alloc_op         (alloc_op),
        .alloc_rd         (alloc_rd),
        .alloc_pred_taken (alloc_pred_taken),
        .full             (full),
        .alloc_tag        (alloc_tag),
        .alloc_fire       (alloc_fire),
        .ex_valid         (ex_valid),
        .ex_tag           (ex_tag),
        .ex_data          (ex_data),
        .ex_taken         (ex_taken),
        .ex_target        (ex_target),
        .lookup1_tag      (lookup1_tag),
        .lookup2_tag      (lookup2_tag),
        .lookup1_done     (lookup1_done),
        .lookup2_done     (lookup2_done),
        .lookup1_data     (lookup1_data),
        .lookup2_data     (lookup2_data),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_data      (commit_data),
        .commit_tag       (commit_tag),
        .store_commit     (store_commit),
        .store_tag        (store_tag),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .flush            (flush)
    );

    rename_map map0 (
        .clk          (clk),
        .rst          (rst),
        .alloc_fire   (alloc_fire),
        .alloc_rd     (alloc_rd),
        .alloc_tag    (alloc_tag),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .flush        (flush),
        .src1_name    (src1_name),
        .src2_name    (src2_name),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .lookup1_done (lookup1_done),
        .lookup2_done (lookup2_done),
        .lookup1_data (lookup1_data),
        .lookup2_data (lookup2_data),
        .lookup1_tag  (lookup1_tag),
        .lookup2_tag  (lookup2_tag),
        .src1_ready   (src1_ready),
        .src2_ready   (src2_ready),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .src1_data    (src1_data),
        .src2_data    (src2_data)
    );

    arch_regfile rf0 (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .src1_name    (src1_name),
        .src2_name    (src2_name),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2)
    );

endmodule

// File: testbench/ooo_retire_tb.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module ooo_retire_tb;

    localparam int TIMEOUT = 100;

    logic               clk;
    logic               rst;
    logic               alloc_valid;
    rob_pkg::op_kind_e  alloc_op;
    rob_pkg::reg_name_t alloc_rd;
    logic               alloc_pred_taken;
    logic               full;
    rob_pkg::tag_t      alloc_tag;
    rob_pkg::reg_name_t src1_name;
    rob_pkg::reg_name_t src2_name;
    logic               src1_ready;
    rob_pkg::tag_t      src1_tag;
    rob_pkg::data_t     src1_data;
    logic               src2_ready;
    rob_pkg::tag_t      src2_tag;
    rob_pkg::data_t     src2_data;
    logic               ex_valid;
    rob_pkg::tag_t      ex_tag;
    rob_pkg::data_t     ex_data;
    logic               ex_taken;
    rob_pkg::addr_t     ex_target;
    logic               commit_valid;
    rob_pkg::reg_name_t commit_rd;
    rob_pkg::data_t     commit_data;
    rob_pkg::tag_t      commit_tag;
    logic               store_commit;
    rob_pkg::tag_t      store_tag;
    logic               redirect_valid;
    rob_pkg::addr_t     redirect_pc;

    integer         seed;
    rob_pkg::tag_t  exp_tail;
    // expected architectural state, built from observed commits
    rob_pkg::data_t arch [32];

    ooo_retire_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input logic [31:0] exp, input logic [31:0] act, input string what);
        if (exp !== act) begin
            $display("FAIL %0t ns: %s, expected %h, got %h", $time, what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // slot 0 is skipped when the tail wraps
    function automatic rob_pkg::tag_t next_tag(input rob_pkg::tag_t t);
        return (t == rob_pkg::tag_t'(`ROB_DEPTH - 1)) ? rob_pkg::tag_t'(1) : t + 1'b1;
    endfunction

    task automatic alloc(input rob_pkg::op_kind_e op, input rob_pkg::reg_name_t rd,
                         input logic pred, output rob_pkg::tag_t tag);
        @(posedge clk);
        alloc_valid      <= 1'b1;
        alloc_op         <= op;
        alloc_rd         <= rd;
        alloc_pred_taken <= pred;
        @(negedge clk);
        check(0, full, "full during allocation");
        check(exp_tail, alloc_tag, "alloc_tag");
        tag      = alloc_tag;
        exp_tail = next_tag(exp_tail);
        @(posedge clk);
        alloc_valid <= 1'b0;
    endtask

    task automatic complete(input rob_pkg::tag_t tag, input rob_pkg::data_t data,
                            input logic taken, input rob_pkg::addr_t target);
        @(posedge clk);
        ex_valid  <= 1'b1;
        ex_tag    <= tag;
        ex_data   <= data;
        ex_taken  <= taken;
        ex_target <= target;
        @(posedge clk);
        ex_valid  <= 1'b0;
    endtask

    // kind 0 register commit, 1 store, 2 redirect
    task automatic wait_retire(output int kind);
        kind = -1;
        for (int n = 0; n < TIMEOUT && kind < 0; n++) begin
            @(negedge clk);
            kind = store_commit ? 1 : commit_valid ? 0 : redirect_valid ? 2 : -1;
        end
        if (kind < 0) begin
            $display("no retire output appeared within %0d cycles", TIMEOUT);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    endtask

    task automatic expect_commit(input rob_pkg::tag_t tag, input rob_pkg::reg_name_t rd,
                                 input rob_pkg::data_t data);
        int kind;
        wait_retire(kind);
        check(0, kind, "retire kind, register commit expected");
        check(tag, commit_tag, "commit_tag");
        check(rd, commit_rd, "commit_rd");
        check(data, commit_data, "commit_data");
        if (rd != '0) begin
            arch[rd] = data;
        end
    endtask

    task automatic check_sources(input logic ready, input rob_pkg::tag_t tag,
                                 input rob_pkg::data_t data);
        check(ready, src1_ready, "src1_ready");
        check(ready, src2_ready, "src2_ready");
        check(tag, src1_tag, "src1_tag");
        check(tag, src2_tag, "src2_tag");
        if (ready) begin
            check(data, src1_data, "src1_data");
            check(data, src2_data, "src2_data");
        end
    endtask

    task automatic expect_source(input rob_pkg::reg_name_t name, input logic ready,
                                 input rob_pkg::tag_t tag, input rob_pkg::data_t data);
        @(posedge clk);
        src1_name <= name;
        src2_name <= name;
        @(negedge clk);
        check_sources(ready, tag, data);
    endtask

    task automatic test_in_order();
        rob_pkg::tag_t  tags [4];
        rob_pkg::data_t vals [4];
        for (int i = 0; i < 4; i++) begin
            alloc(rob_pkg::op_alu, i + 1, 1'b0, tags[i]);
            vals[i] = $random(seed);
        end
        for (int i = 3; i >= 0; i--) begin
            complete(tags[i], vals[i], 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) begin
            expect_commit(tags[i], i + 1, vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            expect_source(i + 1, 1'b1, '0, vals[i]);
        end
    endtask

    task automatic test_back_pressure();
        rob_pkg::tag_t  tags [15];
        int             count;
        count = 0;
        @(negedge clk);
        while (!full && count < 15) begin
            alloc(rob_pkg::op_alu, 5'd9, 1'b0, tags[count]);
            count++;
            @(negedge clk);
        end
        check(15, count, "accepted allocations before full");
        check(1, full, "full after 15 allocations");
        @(posedge clk);
        alloc_valid <= 1'b1;
        repeat (2) @(posedge clk);
        alloc_valid <= 1'b0;
        @(negedge clk);
        check(exp_tail, alloc_tag, "alloc_tag while full");
        // drain in order, the first commit frees one slot
        for (int i = 0; i < 15; i++) begin
            complete(tags[i], $random(seed), 1'b0, '0);
            expect_commit(tags[i], 5'd9, ex_data);
            check(0, full, "full after a commit");
        end
    endtask

    task automatic test_store();
        rob_pkg::tag_t  ta;
        rob_pkg::tag_t  ts;
        rob_pkg::tag_t  tc;
        rob_pkg::data_t va;
        rob_pkg::data_t vc;
        int             kind;
        va = $random(seed);
        vc = $random(seed);
        alloc(rob_pkg::op_alu, 5'd5, 1'b0, ta);
        alloc(rob_pkg::op_store, 5'd0, 1'b0, ts);
        alloc(rob_pkg::op_alu, 5'd6, 1'b0, tc);
        complete(tc, vc, 1'b0, '0);
        complete(ts, $random(seed), 1'b0, '0);
        complete(ta, va, 1'b0, '0);
        expect_commit(ta, 5'd5, va);
        wait_retire(kind);
        check(1, kind, "retire kind, store expected");
        check(ts, store_tag, "store_tag");
        check(0, commit_valid, "register write for a store");
        expect_commit(tc, 5'd6, vc);
    endtask

    task automatic test_flush();
        rob_pkg::tag_t  tbr;
        rob_pkg::tag_t  t1;
        rob_pkg::tag_t  t2;
        rob_pkg::addr_t target;
        int             kind;
        target = $random(seed);
        alloc(rob_pkg::op_branch, 5'd0, 1'b0, tbr);
        alloc(rob_pkg::op_alu, 5'd1, 1'b0, t1);
        alloc(rob_pkg::op_alu, 5'd2, 1'b0, t2);
        complete(t2, $random(seed), 1'b0, '0);
        complete(t1, $random(seed), 1'b0, '0);
        complete(tbr, '0, 1'b1, target);
        wait_retire(kind);
        check(2, kind, "retire kind, redirect expected");
        check(target, redirect_pc, "redirect_pc");
        exp_tail = 1;
        // younger entries are gone and must stay silent
        repeat (6) begin
            @(negedge clk);
            check(0, commit_valid, "commit from a flushed entry");
        end
        check(0, full, "full after flush");
        check(1, alloc_tag, "alloc_tag after flush");
        expect_source(5'd1, 1'b1, '0, arch[1]);
        expect_source(5'd2, 1'b1, '0, arch[2]);
    endtask

    task automatic test_forwarding();
        rob_pkg::tag_t  t7;
        rob_pkg::tag_t  tbr;
        rob_pkg::tag_t  t8;
        rob_pkg::data_t v7;
        rob_pkg::data_t v8;
        v7 = $random(seed);
        v8 = $random(seed);
        alloc(rob_pkg::op_alu, 5'd7, 1'b0, t7);
        expect_source(5'd7, 1'b0, t7, '0);
        alloc(rob_pkg::op_branch, 5'd0, 1'b1, tbr);
        alloc(rob_pkg::op_alu, 5'd8, 1'b0, t8);
        complete(tbr, '0, 1'b1, $random(seed));
        complete(t8, v8, 1'b0, '0);
        complete(t7, v7, 1'b0, '0);
        // done but not yet retired
        @(negedge clk);
        check_sources(1'b1, t7, v7);
        expect_commit(t7, 5'd7, v7);
        expect_commit(t8, 5'd8, v8);
        expect_source(5'd7, 1'b1, '0, v7);
    endtask

    task automatic test_reg_zero();
        rob_pkg::tag_t  t0;
        rob_pkg::data_t v0;
        v0 = $random(seed) | 1;
        alloc(rob_pkg::op_alu, 5'd0, 1'b0, t0);
        expect_source(5'd0, 1'b1, '0, '0);
        complete(t0, v0, 1'b0, '0);
        expect_commit(t0, 5'd0, v0);
        expect_source(5'd0, 1'b1, '0, '0);
    endtask

    initial begin
        seed             = 32'hc812b5cb;
        rst              = 1'b1;
        alloc_valid      = 1'b0;
        alloc_op         = rob_pkg::op_alu;
        alloc_rd         = '0;
        alloc_pred_taken = 1'b0;
        src1_name        = '0;
        src2_name        = '0;
        ex_valid         = 1'b0;
        ex_tag           = '0;
        ex_data          = '0;
        ex_taken         = 1'b0;
        ex_target        = '0;
        exp_tail         = 1;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check(0, commit_valid, "commit_valid after reset");
        check(0, store_commit, "store_commit after reset");
        check(0, redirect_valid, "redirect_valid after reset");
        check(0, full, "full after reset");
        check(1, alloc_tag, "alloc_tag after reset");
        test_in_order();
        test_back_pressure();
        test_store();
        test_flush();
        test_forwarding();
        test_reg_zero();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/reorder_buffer.sv
hdl/rename_map.sv
hdl/arch_regfile.sv
hdl/ooo_retire_top.sv
testbench/ooo_retire_tb.sv

// File: Bender.yml
package:
  name: ooo_retire

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rob_pkg.sv
      - hdl/reorder_buffer.sv
      - hdl/rename_map.sv
      - hdl/arch_regfile.sv
      - hdl/ooo_retire_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/ooo_retire_tb.sv
